//--- Bender.yml
package:
  name: xm_regs

sources:
  - include_dirs:
      - logic
    files:
      - logic/xm_pkg.sv
      - logic/bus_sync.sv
      - logic/reg_decoder.sv
      - logic/vram_pointer.sv
      - logic/vram_port.sv
      - logic/xm_regs_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock.sv
      - tests/xm_regs_assert.sv
      - tests/xm_regs_tb.sv

//--- files.f
+incdir+logic
logic/xm_pkg.sv
logic/bus_sync.sv
logic/reg_decoder.sv
logic/vram_pointer.sv
logic/vram_port.sv
logic/xm_regs_top.sv
tests/tb_clock.sv
tests/xm_regs_assert.sv
tests/xm_regs_tb.sv

//--- logic/bus_sync.sv
// cpu bus synchronizer
// turns the falling edge of chip select into one byte read or write command
`timescale 1ns/1ps
`include "xm_params.svh"

module bus_sync (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             bus_cs_n_i,        // async select, low active
    input  logic             bus_rd_nwr_i,      // 1 read, 0 write
    input  logic [3:0]       bus_reg_num_i,
    input  logic             bus_bytesel_i,
    input  logic [7:0]       bus_data_i,
    output xm_pkg::bus_cmd_t bus_cmd_o
);
    import xm_pkg::*;

    logic [`XM_SYNC_STAGES-1:0] cs_sync;        // bit 0 is first stage
    logic                       cs_prev;
    logic                       cs_fall;
    logic                       wr_stb;
    logic                       rd_stb;
    reg_num_e                   reg_num;
    logic                       bytesel;
    logic [7:0]                 data_byte;

    assign cs_fall = cs_prev & ~cs_sync[`XM_SYNC_STAGES-1];    // select just went low

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync <= '1;                      // bus idles deselected
            cs_prev <= 1'b1;
            wr_stb  <= 1'b0;
            rd_stb  <= 1'b0;
            reg_num <= INERT_0;                 // keeps read mux defined
            bytesel <= 1'b0;
        end else begin
            cs_sync <= {cs_sync[`XM_SYNC_STAGES-2:0], bus_cs_n_i};
            cs_prev <= cs_sync[`XM_SYNC_STAGES-1];
            wr_stb  <= cs_fall & ~bus_rd_nwr_i;
            rd_stb  <= cs_fall & bus_rd_nwr_i;
            if (cs_fall) begin
                reg_num <= reg_num_e'(bus_reg_num_i);   // bus lines long settled
                bytesel <= bus_bytesel_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            data_byte <= bus_data_i;
        end
    end

    assign bus_cmd_o = '{write_strobe: wr_stb, read_strobe: rd_stb, reg_num: reg_num,
                         bytesel: bytesel, data: data_byte};

endmodule

//--- logic/reg_decoder.sv
// register decoder
// maps byte writes and reads onto pointer loads and vram commands
`timescale 1ns/1ps
`include "xm_params.svh"

module reg_decoder (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  xm_pkg::bus_cmd_t                       bus_cmd_i,
    input  xm_pkg::ptr_state_t [`XM_NUM_PTR-1:0]   ptr_state_i,
    output xm_pkg::ptr_load_t  [`XM_NUM_PTR-1:0]   ptr_load_o,
    output xm_pkg::vram_cmd_t                      vram_cmd_o
);
    import xm_pkg::*;

    logic [7:0]                       data_even;    // even byte of any data reg
    logic [7:0]                       other_even;   // generic even byte
    reg_num_e                         other_reg;    // owner of other_even
    logic [7:0]                       even_byte;
    ptr_load_t [`XM_NUM_PTR-1:0]      load_d;
    vram_cmd_t                        cmd_d;
    ptr_idx_e                         p;

    // pointer a pointer register or data write belongs to
    function automatic ptr_idx_e ptr_of(input reg_num_e r);
        case (r)
            RD_INCR, RD_ADDR:                ptr_of = PTR_RD;
            WR_INCR, WR_ADDR, DATA, DATA_2:  ptr_of = PTR_WR;
            default:                         ptr_of = PTR_RW;
        endcase
    endfunction

    // stale even byte from another register counts as zero
    assign even_byte = (other_reg == bus_cmd_i.reg_num) ? other_even : 8'h00;
    assign p         = ptr_of(bus_cmd_i.reg_num);

    always_comb begin
        for (int i = 0; i < `XM_NUM_PTR; i++) begin
            load_d[i]      = '0;
            load_d[i].data = bus_cmd_i.data;
            load_d[i].even = even_byte;
        end
        cmd_d = '0;

        if (bus_cmd_i.write_strobe) begin
            if (!bus_cmd_i.bytesel) begin
                case (bus_cmd_i.reg_num)
                    RD_ADDR, WR_ADDR, RW_ADDR: load_d[p].load_addr_hi = 1'b1;
                    default: ;                              // latched in the ff block
                endcase
            end else begin
                case (bus_cmd_i.reg_num)
                    RD_INCR, WR_INCR, RW_INCR: load_d[p].load_incr = 1'b1;
                    WR_ADDR: load_d[p].load_addr_lo = 1'b1;
                    RD_ADDR, RW_ADDR: begin
                        load_d[p].load_addr_lo = 1'b1;
                        cmd_d.valid = 1'b1;                 // read at the new address
                        cmd_d.ptr   = p;
                        cmd_d.data  = {ptr_state_i[p].addr[`XM_ADDR_W-1:8], bus_cmd_i.data};
                    end
                    DATA, DATA_2, RW_DATA, RW_DATA_2: begin
                        cmd_d.valid = 1'b1;
                        cmd_d.wr    = 1'b1;
                        cmd_d.ptr   = p;                    // wr or rw
                        cmd_d.data  = {data_even, bus_cmd_i.data};
                    end
                    default: ;                              // inert registers
                endcase
            end
        end

        // odd byte read of a data reg fetches the next word
        if (bus_cmd_i.read_strobe && bus_cmd_i.bytesel) begin
            case (bus_cmd_i.reg_num)
                DATA, DATA_2: begin
                    cmd_d.valid = 1'b1;
                    cmd_d.ptr   = PTR_RD;
                    cmd_d.data  = ptr_state_i[PTR_RD].addr;
                end
                RW_DATA, RW_DATA_2: begin
                    cmd_d.valid = 1'b1;
                    cmd_d.ptr   = PTR_RW;
                    cmd_d.data  = ptr_state_i[PTR_RW].addr;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr_load_o <= '0;
            vram_cmd_o <= '0;
            other_reg  <= INERT_0;              // never an incr register
        end else begin
            ptr_load_o <= load_d;
            vram_cmd_o <= cmd_d;
            if (bus_cmd_i.write_strobe && !bus_cmd_i.bytesel) begin
                case (bus_cmd_i.reg_num)
                    RD_ADDR, WR_ADDR, RW_ADDR: ;    // goes to the pointer
                    DATA, DATA_2, RW_DATA, RW_DATA_2: data_even <= bus_cmd_i.data;
                    default: begin
                        other_even <= bus_cmd_i.data;
                        other_reg  <= bus_cmd_i.reg_num;
                    end
                endcase
            end
        end
    end

endmodule

//--- logic/vram_pointer.sv
// vram address pointer
// address and increment loaded bytewise, address advances by incr on step
`timescale 1ns/1ps
`include "xm_params.svh"

module vram_pointer (
    input  logic               clk,
    input  logic               reset_i,
    input  xm_pkg::ptr_load_t  load_i,
    input  logic               step_i,      // one cycle after an accepted access
    output xm_pkg::ptr_state_t state_o
);

    logic [`XM_ADDR_W-1:0] addr;
    logic [`XM_ADDR_W-1:0] incr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr <= '0;
            incr <= '0;
        end else begin
            if (load_i.load_addr_hi) begin
                addr[`XM_ADDR_W-1:8] <= load_i.data;
            end else if (load_i.load_addr_lo) begin
                addr[7:0] <= load_i.data;
            end else if (step_i) begin
                addr <= addr + incr;        // wraps at top of vram
            end
            if (load_i.load_incr) begin
                incr <= {load_i.even, load_i.data};
            end
        end
    end

    assign state_o = '{addr: addr, incr: incr};

endmodule

//--- logic/vram_port.sv
// vram access port
// holds one request through video cycles, steps the pointer and captures reads
`timescale 1ns/1ps
`include "xm_params.svh"

module vram_port (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  xm_pkg::vram_cmd_t                    vram_cmd_i,
    input  xm_pkg::ptr_state_t [`XM_NUM_PTR-1:0] ptr_state_i,
    input  xm_pkg::bus_cmd_t                     bus_cmd_i,
    input  logic                                 vgen_sel_i,    // video owns vram
    input  logic [`XM_ADDR_W-1:0]                vram_data_i,
    output logic [`XM_NUM_PTR-1:0]               step_o,
    output xm_pkg::vram_req_t                    vram_req_o,
    output logic [7:0]                           bus_data_o
);
    import xm_pkg::*;

    logic                  pend_q;          // request waiting for video
    logic                  held_wr;
    ptr_idx_e              held_ptr;
    logic [`XM_ADDR_W-1:0] held_addr;
    logic [`XM_ADDR_W-1:0] held_data;
    logic                  cur_wr;
    ptr_idx_e              cur_ptr;
    logic [`XM_ADDR_W-1:0] cur_addr;
    logic [`XM_ADDR_W-1:0] cur_data;
    logic                  sel;
    logic                  accept;
    logic [`XM_NUM_PTR-1:0] step_q;
    logic                  ack_q;           // read data on vram_data_i now
    ptr_idx_e              ack_ptr;
    logic [`XM_ADDR_W-1:0] rd_word;
    logic [`XM_ADDR_W-1:0] rw_word;
    logic [`XM_ADDR_W-1:0] rd_mux;

    // a fresh command goes straight out, so sel follows the strobe by one cycle
    always_comb begin
        if (vram_cmd_i.valid) begin
            cur_wr   = vram_cmd_i.wr;
            cur_ptr  = vram_cmd_i.ptr;
            cur_data = vram_cmd_i.data;
            // reads carry their address, writes use the pointer
            cur_addr = vram_cmd_i.wr ? ptr_state_i[vram_cmd_i.ptr].addr : vram_cmd_i.data;
        end else begin
            cur_wr   = held_wr;
            cur_ptr  = held_ptr;
            cur_data = held_data;
            cur_addr = held_addr;
        end
    end

    assign sel    = vram_cmd_i.valid | pend_q;
    assign accept = sel & ~vgen_sel_i;      // granted at this edge

    assign vram_req_o = '{sel: sel, wr: sel & cur_wr, addr: cur_addr, data: cur_data};
    assign step_o     = step_q;

    always_ff @(posedge clk) begin
        if (vram_cmd_i.valid) begin
            held_wr   <= cur_wr;
            held_ptr  <= cur_ptr;
            held_addr <= cur_addr;
            held_data <= cur_data;
        end
        ack_ptr <= cur_ptr;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q  <= 1'b0;
            step_q  <= '0;
            ack_q   <= 1'b0;
            rd_word <= '0;
            rw_word <= '0;
        end else begin
            pend_q <= sel & vgen_sel_i;     // stalled, keep holding
            step_q <= '0;
            if (accept) begin
                step_q[cur_ptr] <= 1'b1;
            end
            ack_q <= accept & ~cur_wr;
            if (ack_q) begin
                if (ack_ptr == PTR_RD) begin
                    rd_word <= vram_data_i;
                end else if (ack_ptr == PTR_RW) begin
                    rw_word <= vram_data_i;
                end
            end
        end
    end

    // readback word for the latched register
    always_comb begin
        case (bus_cmd_i.reg_num)
            RD_INCR:            rd_mux = ptr_state_i[PTR_RD].incr;
            RD_ADDR:            rd_mux = ptr_state_i[PTR_RD].addr;
            WR_INCR:            rd_mux = ptr_state_i[PTR_WR].incr;
            WR_ADDR:            rd_mux = ptr_state_i[PTR_WR].addr;
            RW_INCR:            rd_mux = ptr_state_i[PTR_RW].incr;
            RW_ADDR:            rd_mux = ptr_state_i[PTR_RW].addr;
            DATA, DATA_2:       rd_mux = rd_word;
            RW_DATA, RW_DATA_2: rd_mux = rw_word;
            default:            rd_mux = '0;        // inert
        endcase
    end

    assign bus_data_o = bus_cmd_i.bytesel ? rd_mux[7:0] : rd_mux[`XM_ADDR_W-1:8];

endmodule

//--- logic/xm_params.svh
// host register block parameters
// widths, pointer count and synchronizer depth
`ifndef XM_PARAMS_SVH
`define XM_PARAMS_SVH

// vram address and word width
`define XM_ADDR_W 16

// rd, wr and rw pointers
`define XM_NUM_PTR 3

// flops on the chip select path before edge detect
`define XM_SYNC_STAGES 2

`endif

//--- logic/xm_pkg.sv
// host register block types
// register numbers and the structs passed between blocks
`include "xm_params.svh"

package xm_pkg;

    typedef enum logic [3:0] {
        INERT_0   = 4'd0,               // was xr_addr
        INERT_1   = 4'd1,               // was xr_data
        RD_INCR   = 4'd2,
        RD_ADDR   = 4'd3,               // odd byte triggers read
        WR_INCR   = 4'd4,
        WR_ADDR   = 4'd5,
        DATA      = 4'd6,               // write via wr, read via rd
        DATA_2    = 4'd7,
        INERT_8   = 4'd8,               // was sys_ctrl
        INERT_9   = 4'd9,               // was timer
        UNUSED_A  = 4'd10,
        UNUSED_B  = 4'd11,
        RW_INCR   = 4'd12,
        RW_ADDR   = 4'd13,              // odd byte triggers read
        RW_DATA   = 4'd14,
        RW_DATA_2 = 4'd15
    } reg_num_e;

    typedef enum logic [1:0] {
        PTR_RD = 2'd0,
        PTR_WR = 2'd1,
        PTR_RW = 2'd2
    } ptr_idx_e;

    typedef struct packed {
        logic       write_strobe;       // one cycle
        logic       read_strobe;        // one cycle
        reg_num_e   reg_num;            // held until next bus cycle
        logic       bytesel;            // 0 even, 1 odd
        logic [7:0] data;
    } bus_cmd_t;

    typedef struct packed {
        logic       load_addr_hi;
        logic       load_addr_lo;
        logic       load_incr;
        logic [7:0] data;               // bus byte
        logic [7:0] even;               // incr high byte
    } ptr_load_t;

    typedef struct packed {
        logic [`XM_ADDR_W-1:0] addr;
        logic [`XM_ADDR_W-1:0] incr;
    } ptr_state_t;

    typedef struct packed {
        logic                  valid;   // one cycle
        logic                  wr;
        ptr_idx_e              ptr;
        logic [`XM_ADDR_W-1:0] data;    // write word, or address on reads
    } vram_cmd_t;

    typedef struct packed {
        logic                  sel;
        logic                  wr;
        logic [`XM_ADDR_W-1:0] addr;
        logic [`XM_ADDR_W-1:0] data;
    } vram_req_t;

endpackage

//--- logic/xm_regs_top.sv
// host register block top
// bus synchronizer, register decoder, three vram pointers and the vram port
`timescale 1ns/1ps
`include "xm_params.svh"

module xm_regs_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  bus_cs_n_i,
    input  logic                  bus_rd_nwr_i,
    input  logic [3:0]            bus_reg_num_i,
    input  logic                  bus_bytesel_i,
    input  logic [7:0]            bus_data_i,
    output logic [7:0]            bus_data_o,
    input  logic                  vgen_sel_i,
    output xm_pkg::vram_req_t     vram_req_o,
    input  logic [`XM_ADDR_W-1:0] vram_data_i
);
    import xm_pkg::*;

    bus_cmd_t                     bus_cmd;
    ptr_load_t  [`XM_NUM_PTR-1:0] ptr_load;
    ptr_state_t [`XM_NUM_PTR-1:0] ptr_state;
    vram_cmd_t                    vram_cmd;
    logic       [`XM_NUM_PTR-1:0] ptr_step;

    bus_sync bus_sync_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_cmd_o     (bus_cmd)
    );

    reg_decoder reg_decoder_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_cmd_i   (bus_cmd),
        .ptr_state_i (ptr_state),
        .ptr_load_o  (ptr_load),
        .vram_cmd_o  (vram_cmd)
    );

    for (genvar i = 0; i < `XM_NUM_PTR; i++) begin : g_ptr
        vram_pointer vram_pointer_inst (
            .clk     (clk),
            .reset_i (reset_i),
            .load_i  (ptr_load[i]),
            .step_i  (ptr_step[i]),
            .state_o (ptr_state[i])
        );
    end

    vram_port vram_port_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .vram_cmd_i  (vram_cmd),
        .ptr_state_i (ptr_state),
        .bus_cmd_i   (bus_cmd),
        .vgen_sel_i  (vgen_sel_i),
        .vram_data_i (vram_data_i),
        .step_o      (ptr_step),
        .vram_req_o  (vram_req_o),
        .bus_data_o  (bus_data_o)
    );

endmodule

//--- tests/tb_clock.sv
// testbench clock and reset
// free running clock, reset held high for the first cycles
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,    // ns
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                   // release between edges
        reset_o = 1'b0;
    end

endmodule

//--- tests/xm_regs_assert.sv
// vram port assertions
// bound into the register block top to check vram select and write behavior
`timescale 1ns/1ps

module xm_regs_assert (
    input logic              clk,
    input logic              reset_i,
    input logic              vgen_sel_i,
    input xm_pkg::vram_req_t vram_req_i
);

    int fail_count;                         // count of failed assertions

    // flops settle after the first edge in reset
    sel_in_reset: assert property (@(posedge clk) (reset_i ##1 reset_i) |-> !vram_req_i.sel)
        else begin
            $error("vram select asserted during reset");
            fail_count++;
        end

    // request frozen while video owns the memory
    hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        (vram_req_i.sel && vgen_sel_i) |=> (vram_req_i.sel && $stable(vram_req_i)))
        else begin
            $error("vram request changed during a video stall");
            fail_count++;
        end

    // a write opens its own access and never turns a pending read into a write
    wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vram_req_i.wr) |-> $rose(vram_req_i.sel))
        else begin
            $error("vram write rose without a new select");
            fail_count++;
        end

endmodule

bind xm_regs_top xm_regs_assert xm_regs_assert_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .vgen_sel_i (vgen_sel_i),
    .vram_req_i (vram_req_o)
);

//--- tests/xm_regs_tb.sv
// host register block testbench
// table driven cpu bus cycles against a vram model with random video stalls
`timescale 1ns/1ps
`include "xm_params.svh"

module xm_regs_tb;
    import xm_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int BUS_CYCLE  = 16;                     // clocks per bus access
    localparam int CS_LOW     = 8;
    localparam int STALL_BITS = 12;                     // last clocks never stalled
    localparam int SAMPLE_AT  = `XM_SYNC_STAGES + 2;    // one clock after the strobe
    localparam int MAX_STEPS  = 64;

    typedef enum logic [1:0] {OP_WRITE, OP_WRITE_ODD, OP_READ, OP_MEM} op_e;

    typedef struct packed {
        op_e                   op;
        reg_num_e              reg_num;
        logic [`XM_ADDR_W-1:0] addr;                    // model address, OP_MEM only
        logic [`XM_ADDR_W-1:0] value;                   // written or expected word
    } step_t;

    logic                  clk;
    logic                  reset_i;
    logic                  bus_cs_n_i;
    logic                  bus_rd_nwr_i;
    logic [3:0]            bus_reg_num_i;
    logic                  bus_bytesel_i;
    logic [7:0]            bus_data_i;
    logic [7:0]            bus_data_o;
    logic                  vgen_sel_i;
    vram_req_t             vram_req_o;
    logic [`XM_ADDR_W-1:0] vram_data_i;

    logic [`XM_ADDR_W-1:0] vram_mem [0:(1 << `XM_ADDR_W)-1];
    step_t                 steps [0:MAX_STEPS-1];
    int                    num_steps;
    int                    checks;
    int                    errors;
    logic [31:0]           lfsr;
    logic [STALL_BITS-1:0] stall_pat;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) tb_clock_inst (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    xm_regs_top xm_regs_top_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .vgen_sel_i    (vgen_sel_i),
        .vram_req_o    (vram_req_o),
        .vram_data_i   (vram_data_i)
    );

    // vram model, answers in the cycle after acceptance
    always @(posedge clk) begin
        if (vram_req_o.sel && !vgen_sel_i) begin
            if (vram_req_o.wr) begin
                vram_mem[vram_req_o.addr] <= vram_req_o.data;
            end else begin
                vram_data_i <= vram_mem[vram_req_o.addr];
            end
        end
    end

    // preload pattern, every address bit matters
    function automatic logic [15:0] fill_word(input logic [15:0] a);
        fill_word = {a[7:0] ^ 8'h5a, a[15:8] ^ 8'hc3};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_stalls();
        int i;
        for (i = 0; i < STALL_BITS; i++) begin
            lfsr         = lfsr_step(lfsr);
            stall_pat[i] = lfsr[0];                     // one step per bit
        end
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_step(input op_e op, input reg_num_e num, input logic [15:0] addr,
                            input logic [15:0] value);
        steps[num_steps] = '{op: op, reg_num: num, addr: addr, value: value};
        num_steps++;
    endtask

    task automatic build_table();
        // reset values
        add_step(OP_READ, RD_INCR, 16'h0, 16'h0000);
        add_step(OP_READ, RD_ADDR, 16'h0, 16'h0000);
        add_step(OP_READ, WR_INCR, 16'h0, 16'h0000);
        add_step(OP_READ, WR_ADDR, 16'h0, 16'h0000);
        add_step(OP_READ, RW_INCR, 16'h0, 16'h0000);
        add_step(OP_READ, RW_ADDR, 16'h0, 16'h0000);
        // increments and inert registers
        add_step(OP_WRITE, RD_INCR, 16'h0, 16'h0110);
        add_step(OP_READ, RD_INCR, 16'h0, 16'h0110);
        add_step(OP_WRITE, INERT_9, 16'h0, 16'h7733);  // even byte tagged for reg 9
        add_step(OP_WRITE_ODD, RW_INCR, 16'h0, 16'h0005);
        add_step(OP_READ, RW_INCR, 16'h0, 16'h0005);
        add_step(OP_READ, INERT_9, 16'h0, 16'h0000);
        add_step(OP_READ, UNUSED_A, 16'h0, 16'h0000);
        // writes through wr
        add_step(OP_WRITE, WR_INCR, 16'h0, 16'h0003);
        add_step(OP_WRITE, WR_ADDR, 16'h0, 16'h1200);
        add_step(OP_WRITE, DATA, 16'h0, 16'hbeef);
        add_step(OP_WRITE, DATA_2, 16'h0, 16'hcafe);
        add_step(OP_WRITE, DATA, 16'h0, 16'h1357);
        add_step(OP_READ, WR_ADDR, 16'h0, 16'h1209);
        add_step(OP_MEM, INERT_0, 16'h1200, 16'hbeef);
        add_step(OP_MEM, INERT_0, 16'h1203, 16'hcafe);
        add_step(OP_MEM, INERT_0, 16'h1206, 16'h1357);
        // reads through rd, each odd read fetches the next word
        add_step(OP_WRITE, RD_ADDR, 16'h0, 16'h2040);
        add_step(OP_READ, DATA, 16'h0, fill_word(16'h2040));
        add_step(OP_READ, DATA_2, 16'h0, fill_word(16'h2150));
        add_step(OP_READ, DATA, 16'h0, fill_word(16'h2260));
        add_step(OP_READ, RD_ADDR, 16'h0, 16'h2480);
        add_step(OP_WRITE, RD_ADDR, 16'h0, 16'h1203);
        add_step(OP_READ, DATA, 16'h0, 16'hcafe);
        // rw pointer in both directions
        add_step(OP_WRITE, RW_ADDR, 16'h0, 16'h3000);  // read at 3000, then 3005
        add_step(OP_WRITE, RW_DATA, 16'h0, 16'ha1b2);
        add_step(OP_WRITE, RW_DATA_2, 16'h0, 16'hc3d4);
        add_step(OP_WRITE, RW_ADDR, 16'h0, 16'h3005);
        add_step(OP_READ, RW_DATA, 16'h0, 16'ha1b2);
        add_step(OP_READ, RW_DATA_2, 16'h0, 16'hc3d4);
        add_step(OP_READ, RW_DATA, 16'h0, fill_word(16'h300f));
        add_step(OP_READ, RW_ADDR, 16'h0, 16'h3019);
        add_step(OP_MEM, INERT_0, 16'h3005, 16'ha1b2);
        add_step(OP_MEM, INERT_0, 16'h300a, 16'hc3d4);
    endtask

    // one cpu byte access, starts and ends on a falling edge
    task automatic bus_access(input logic rd, input reg_num_e num, input logic odd,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int c;
        rdata         = 8'h00;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_data_i    = wdata;
        bus_cs_n_i    = 1'b0;
        for (c = 0; c < BUS_CYCLE; c++) begin
            vgen_sel_i = (c < STALL_BITS) ? stall_pat[c] : 1'b0;
            if (c == CS_LOW) begin
                bus_cs_n_i = 1'b1;
            end
            @(negedge clk);
            if (c + 1 == SAMPLE_AT) begin
                rdata = bus_data_o;                     // before any pre-read lands
            end
        end
        if (vram_req_o.sel) begin
            errors++;
            $display("error at %0t ns: VRAM access still pending at end of bus cycle", $time);
        end
    endtask

    task automatic run_step(input int idx);
        step_t      s;
        logic [7:0] hi;
        logic [7:0] lo;
        int         errs_before;
        s           = steps[idx];
        errs_before = errors;
        draw_stalls();
        case (s.op)
            OP_WRITE: begin
                bus_access(1'b0, s.reg_num, 1'b0, s.value[15:8], hi);
                bus_access(1'b0, s.reg_num, 1'b1, s.value[7:0], lo);
            end
            OP_WRITE_ODD: begin
                bus_access(1'b0, s.reg_num, 1'b1, s.value[7:0], lo);
            end
            OP_READ: begin
                bus_access(1'b1, s.reg_num, 1'b0, 8'h00, hi);
                bus_access(1'b1, s.reg_num, 1'b1, 8'h00, lo);
                check_value({hi, lo}, s.value, $sformatf("read of %s", s.reg_num.name()));
            end
            default: begin
                check_value(vram_mem[s.addr], s.value, $sformatf("vram word at %h", s.addr));
            end
        endcase
        $display("step %0d %s %s addr %h value %h: %s", idx, s.op.name(), s.reg_num.name(),
                 s.addr, s.value, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int a;
        int i;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        vgen_sel_i    = 1'b0;
        vram_data_i   = '0;
        stall_pat     = '0;
        lfsr          = 32'hcf27b186;
        checks        = 0;
        errors        = 0;
        for (a = 0; a < (1 << `XM_ADDR_W); a++) begin
            vram_mem[a] = fill_word(a[15:0]);
        end
        build_table();
        @(negedge clk);
        while (reset_i) begin
            @(negedge clk);
        end
        check_value({15'b0, vram_req_o.sel}, 16'h0000, "vram select after reset");
        for (i = 0; i < num_steps; i++) begin
            run_step(i);
        end
        errors += xm_regs_top_inst.xm_regs_assert_inst.fail_count;
        $display("steps %0d, checks %0d, errors %0d", num_steps, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, 40 bus cycles per table step
    initial begin
        wait (num_steps > 0);
        #(num_steps * 40 * BUS_CYCLE * CLK_PERIOD);
        $display("timeout: the table did not finish within %0d bus cycles", num_steps * 40);
        $display("TEST FAILED");
        $finish;
    end

endmodule
